// File: rtl/hbus_pkg.sv
// HyperBus bridge shared definitions

package hbus_pkg;

  // User data word width
  localparam int FIFO_DW = 32;

  // One beat on the native bus
  localparam int HBUS_DW = 16;

  // Native bus address width
  localparam int HBUS_AW = 32;

  // Bus beats that make up one user word
  localparam int BEATS = FIFO_DW / HBUS_DW;

  // Entries per FIFO, also the limit on outstanding reads
  localparam int FIFO_DEPTH = 4;

  // FIFO pointer width
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Beat counter and read credit counter width
  localparam int CNT_W = 3;

  // Command entry queued between request port and transfer FSM
  typedef struct packed {
    logic               is_read;
    logic [HBUS_AW-1:0] addr;
  } hbus_cmd_t;

endpackage

// File: rtl/hbus_sync_fifo.sv
// Synchronous FIFO with selectable payload type

module hbus_sync_fifo #(
  parameter type payload_t = logic [hbus_pkg::FIFO_DW-1:0]
) (
  input  logic     clk,
  input  logic     hbus_rst,

  // Write side
  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,

  // Read side, head entry always shown
  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     empty_o
);

  payload_t mem [hbus_pkg::FIFO_DEPTH];

  logic [hbus_pkg::PTR_W-1:0] wr_ptr;
  logic [hbus_pkg::PTR_W-1:0] rd_ptr;
  logic [hbus_pkg::CNT_W-1:0] count;

  assign full_o     = (count == hbus_pkg::CNT_W'(hbus_pkg::FIFO_DEPTH));
  assign empty_o    = (count == '0);
  assign pop_data_o = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        if (wr_ptr == hbus_pkg::PTR_W'(hbus_pkg::FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr == hbus_pkg::PTR_W'(hbus_pkg::FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Occupancy, unchanged on simultaneous push and pop
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      count <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Callers must respect the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (hbus_rst)
    !(push_i && full_o));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (hbus_rst)
    !(pop_i && empty_o));

endmodule

// File: rtl/hbus_req_port.sv
// User request port with read credit tracking

module hbus_req_port (
  input  logic                         clk,
  input  logic                         hbus_rst,

  // User request
  input  logic                         req_valid_i,
  input  logic                         req_write_i,
  input  logic [hbus_pkg::HBUS_AW-1:0] req_addr_i,
  input  logic [hbus_pkg::FIFO_DW-1:0] req_wdata_i,
  output logic                         req_ready_o,

  // FIFO status
  input  logic                         cmd_full_i,
  input  logic                         tx_full_i,
  input  logic                         rsp_pop_i,

  // Command FIFO write side
  output logic                         cmd_push_o,
  output hbus_pkg::hbus_cmd_t          cmd_data_o,

  // TX FIFO write side
  output logic                         tx_push_o,
  output logic [hbus_pkg::FIFO_DW-1:0] tx_data_o
);

  logic [hbus_pkg::CNT_W-1:0] credit_cnt;
  logic                       credit_ok;
  logic                       accept;
  logic                       rd_accept;

  // Reads in flight plus words waiting in the RX FIFO
  assign credit_ok = (credit_cnt < hbus_pkg::CNT_W'(hbus_pkg::FIFO_DEPTH));

  // Writes need TX space, reads need a credit
  assign req_ready_o = !cmd_full_i && (req_write_i ? !tx_full_i : credit_ok);

  assign accept    = req_valid_i && req_ready_o;
  assign rd_accept = accept && !req_write_i;

  assign cmd_push_o         = accept;
  assign cmd_data_o.is_read = !req_write_i;
  assign cmd_data_o.addr    = req_addr_i;

  assign tx_push_o = accept && req_write_i;
  assign tx_data_o = req_wdata_i;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      credit_cnt <= '0;
    end else begin
      case ({rd_accept, rsp_pop_i})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // RX FIFO can never overflow
  a_credit_max: assert property (@(posedge clk) disable iff (hbus_rst)
    credit_cnt <= hbus_pkg::CNT_W'(hbus_pkg::FIFO_DEPTH));

  // Every popped response was requested earlier
  a_pop_has_credit: assert property (@(posedge clk) disable iff (hbus_rst)
    rsp_pop_i |-> credit_cnt != '0);

endmodule

// File: rtl/hbus_xfer_fsm.sv
// Bus-side transfer FSM
// Splits user words into HyperBus beats and back

module hbus_xfer_fsm (
  input  logic                         clk,
  input  logic                         hbus_rst,

  // Command FIFO read side
  input  logic                         cmd_empty_i,
  input  hbus_pkg::hbus_cmd_t          cmd_data_i,
  output logic                         cmd_pop_o,

  // TX FIFO read side
  input  logic [hbus_pkg::FIFO_DW-1:0] tx_data_i,
  output logic                         tx_pop_o,

  // RX FIFO write side
  output logic                         rx_push_o,
  output logic [hbus_pkg::FIFO_DW-1:0] rx_data_o,

  // Native bus
  output logic [hbus_pkg::HBUS_AW-1:0] hbus_adr_o,
  output logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_o,
  output logic                         hbus_rrq_o,
  output logic                         hbus_wrq_o,
  input  logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_i,
  input  logic                         hbus_ready_i,
  input  logic                         hbus_valid_i,
  input  logic                         hbus_busy_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ
  } state_t;

  state_t state;

  logic [hbus_pkg::CNT_W-1:0]   beat_cnt;
  logic [hbus_pkg::FIFO_DW-1:0] data_sr;
  logic [hbus_pkg::HBUS_AW-1:0] adr_q;

  logic start;
  logic wr_beat;
  logic rd_beat;
  logic last_beat;
  logic req_active;

  // Start a transaction only on a quiet bus
  assign start = (state == ST_IDLE) && !cmd_empty_i && !hbus_busy_i;

  assign cmd_pop_o = start;
  assign tx_pop_o  = start && !cmd_data_i.is_read;

  assign hbus_wrq_o = (state == ST_WRITE);
  assign hbus_rrq_o = (state == ST_READ);
  assign req_active = hbus_wrq_o || hbus_rrq_o;

  assign wr_beat   = hbus_wrq_o && hbus_ready_i;
  assign rd_beat   = hbus_rrq_o && hbus_valid_i;
  assign last_beat = (beat_cnt == hbus_pkg::CNT_W'(hbus_pkg::BEATS - 1));

  assign hbus_adr_o = adr_q;

  // Most significant beat goes out first
  assign hbus_dat_o = data_sr[hbus_pkg::FIFO_DW-1 -: hbus_pkg::HBUS_DW];

  // Assembled word goes into the RX FIFO with the final beat
  assign rx_push_o = rd_beat && last_beat;
  assign rx_data_o = {data_sr[hbus_pkg::FIFO_DW-hbus_pkg::HBUS_DW-1:0], hbus_dat_i};

  // Control
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          beat_cnt <= '0;
          if (start) begin
            state <= cmd_data_i.is_read ? ST_READ : ST_WRITE;
          end
        end

        ST_WRITE: begin
          if (wr_beat) begin
            if (last_beat) begin
              state <= ST_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end

        ST_READ: begin
          if (rd_beat) begin
            if (last_beat) begin
              state <= ST_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and data shift register
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= cmd_data_i.addr;
      // Write word is loaded here, read data fills in beat by beat
      if (!cmd_data_i.is_read) begin
        data_sr <= tx_data_i;
      end
    end else if (wr_beat) begin
      data_sr <= data_sr << hbus_pkg::HBUS_DW;
    end else if (rd_beat) begin
      data_sr <= {data_sr[hbus_pkg::FIFO_DW-hbus_pkg::HBUS_DW-1:0], hbus_dat_i};
    end
  end

  // Only one direction on the bus at a time
  a_req_onehot: assert property (@(posedge clk) disable iff (hbus_rst)
    !(hbus_rrq_o && hbus_wrq_o));

  // Address holds for the whole transaction
  a_adr_stable: assert property (@(posedge clk) disable iff (hbus_rst)
    req_active && $past(req_active) |-> $stable(hbus_adr_o));

endmodule

// File: rtl/hbus_fifo.sv
// HyperBus user bridge top level

module hbus_fifo (
  input  logic                         clk,
  input  logic                         hbus_rst,

  // User request
  input  logic                         req_valid_i,
  input  logic                         req_write_i,
  input  logic [hbus_pkg::HBUS_AW-1:0] req_addr_i,
  input  logic [hbus_pkg::FIFO_DW-1:0] req_wdata_i,
  output logic                         req_ready_o,

  // User response
  output logic                         rsp_valid_o,
  output logic [hbus_pkg::FIFO_DW-1:0] rsp_rdata_o,
  input  logic                         rsp_ready_i,

  // Native bus
  output logic [hbus_pkg::HBUS_AW-1:0] hbus_adr_o,
  output logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_o,
  output logic                         hbus_rrq_o,
  output logic                         hbus_wrq_o,
  input  logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_i,
  input  logic                         hbus_ready_i,
  input  logic                         hbus_valid_i,
  input  logic                         hbus_busy_i
);

  hbus_pkg::hbus_cmd_t          cmd_wdata;
  hbus_pkg::hbus_cmd_t          cmd_rdata;
  logic                         cmd_push;
  logic                         cmd_pop;
  logic                         cmd_full;
  logic                         cmd_empty;

  logic [hbus_pkg::FIFO_DW-1:0] tx_wdata;
  logic [hbus_pkg::FIFO_DW-1:0] tx_rdata;
  logic                         tx_push;
  logic                         tx_pop;
  logic                         tx_full;

  logic [hbus_pkg::FIFO_DW-1:0] rx_wdata;
  logic                         rx_push;
  logic                         rx_pop;
  logic                         rx_empty;

  // Response port sits directly on the RX FIFO head
  assign rsp_valid_o = !rx_empty;
  assign rx_pop      = rsp_ready_i && !rx_empty;

  hbus_req_port u_req_port (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .cmd_full_i  (cmd_full),
    .tx_full_i   (tx_full),
    .rsp_pop_i   (rx_pop),
    .cmd_push_o  (cmd_push),
    .cmd_data_o  (cmd_wdata),
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_wdata)
  );

  hbus_sync_fifo #(.payload_t(hbus_pkg::hbus_cmd_t)) cmd_fifo (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .push_i      (cmd_push),
    .push_data_i (cmd_wdata),
    .full_o      (cmd_full),
    .pop_i       (cmd_pop),
    .pop_data_o  (cmd_rdata),
    .empty_o     (cmd_empty)
  );

  // Write data is queued together with its command
  hbus_sync_fifo #(.payload_t(logic [hbus_pkg::FIFO_DW-1:0])) tx_fifo (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .push_i      (tx_push),
    .push_data_i (tx_wdata),
    .full_o      (tx_full),
    .pop_i       (tx_pop),
    .pop_data_o  (tx_rdata),
    .empty_o     ()
  );

  // Read credits keep this FIFO from overflowing
  hbus_sync_fifo #(.payload_t(logic [hbus_pkg::FIFO_DW-1:0])) rx_fifo (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .push_i      (rx_push),
    .push_data_i (rx_wdata),
    .full_o      (),
    .pop_i       (rx_pop),
    .pop_data_o  (rsp_rdata_o),
    .empty_o     (rx_empty)
  );

  hbus_xfer_fsm u_xfer_fsm (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .cmd_empty_i  (cmd_empty),
    .cmd_data_i   (cmd_rdata),
    .cmd_pop_o    (cmd_pop),
    .tx_data_i    (tx_rdata),
    .tx_pop_o     (tx_pop),
    .rx_push_o    (rx_push),
    .rx_data_o    (rx_wdata),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i)
  );

endmodule

// File: testbench/hbus_mem_model.sv
// Behavioral HyperBus controller and memory

module hbus_mem_model (
  input  logic                         clk,
  input  logic                         hbus_rst,

  // Native bus as seen from the controller
  input  logic [hbus_pkg::HBUS_AW-1:0] hbus_adr_i,
  input  logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_i,
  input  logic                         hbus_rrq_i,
  input  logic                         hbus_wrq_i,
  output logic [hbus_pkg::HBUS_DW-1:0] hbus_dat_o,
  output logic                         hbus_ready_o,
  output logic                         hbus_valid_o,
  output logic                         hbus_busy_o,

  // One-cycle report of each finished write
  output logic                         wr_done_o,
  output logic [hbus_pkg::HBUS_AW-1:0] wr_addr_o,
  output logic [hbus_pkg::FIFO_DW-1:0] wr_word_o,
  output int                           wr_beats_o
);

  // Keyed by address and beat index
  logic [hbus_pkg::HBUS_DW-1:0] mem [logic [hbus_pkg::HBUS_AW+7:0]];

  logic [hbus_pkg::FIFO_DW-1:0] wr_word;
  logic                         wr_seen;
  logic                         rd_seen;
  int                           beat;
  int                           busy_cnt;

  function automatic logic [hbus_pkg::HBUS_DW-1:0] beat_value(
    input logic [hbus_pkg::HBUS_AW-1:0] addr,
    input int                           idx
  );
    logic [hbus_pkg::HBUS_AW+7:0] key;
    key = {addr, 8'(idx)};
    if (mem.exists(key)) begin
      return mem[key];
    end
    // Unwritten word is the low address half, then its complement
    return (idx == 0) ? addr[hbus_pkg::HBUS_DW-1:0] : ~addr[hbus_pkg::HBUS_DW-1:0];
  endfunction

  initial begin
    hbus_dat_o   = '0;
    hbus_ready_o = 1'b0;
    hbus_valid_o = 1'b0;
    hbus_busy_o  = 1'b0;
    wr_done_o    = 1'b0;
    wr_addr_o    = '0;
    wr_word_o    = '0;
    wr_beats_o   = 0;
    wr_seen      = 1'b0;
    rd_seen      = 1'b0;
    beat         = 0;
    busy_cnt     = 0;
  end

  always @(posedge clk) begin
    // Beats that transfer on this edge
    if (!hbus_rst && hbus_wrq_i && hbus_ready_o) begin
      mem[{hbus_adr_i, 8'(beat)}] = hbus_dat_i;
      wr_word = {wr_word[hbus_pkg::FIFO_DW-hbus_pkg::HBUS_DW-1:0], hbus_dat_i};
      beat++;
    end
    if (!hbus_rst && hbus_rrq_i && hbus_valid_o) begin
      beat++;
    end
    #1;
    wr_done_o = 1'b0;
    if (hbus_rst) begin
      beat         = 0;
      busy_cnt     = 0;
      wr_seen      = 1'b0;
      rd_seen      = 1'b0;
      hbus_ready_o = 1'b0;
      hbus_valid_o = 1'b0;
      hbus_busy_o  = 1'b0;
    end else begin
      if (wr_seen && !hbus_wrq_i) begin
        wr_done_o  = 1'b1;
        wr_addr_o  = hbus_adr_i;
        wr_word_o  = wr_word;
        wr_beats_o = beat;
      end
      // Busy period after every finished transaction
      if ((wr_seen && !hbus_wrq_i) || (rd_seen && !hbus_rrq_i)) begin
        beat     = 0;
        busy_cnt = $urandom_range(3, 0);
      end
      wr_seen      = hbus_wrq_i;
      rd_seen      = hbus_rrq_i;
      hbus_busy_o  = (busy_cnt != 0);
      if (busy_cnt != 0) begin
        busy_cnt--;
      end
      hbus_ready_o = ($urandom_range(2, 0) != 0);
      hbus_valid_o = ($urandom_range(2, 0) != 0);
      hbus_dat_o   = beat_value(hbus_adr_i, beat);
    end
  end

endmodule

// File: testbench/tb_hbus_fifo.sv
// Testbench for the HyperBus user bridge

module tb_hbus_fifo;

  localparam int TMO      = 200;
  localparam int RSP_HOLD = 0;
  localparam int RSP_ON   = 1;
  localparam int RSP_RAND = 2;

  logic                         clk;
  logic                         hbus_rst;
  logic                         req_valid;
  logic                         req_write;
  logic [hbus_pkg::HBUS_AW-1:0] req_addr;
  logic [hbus_pkg::FIFO_DW-1:0] req_wdata;
  logic                         req_ready;
  logic                         rsp_valid;
  logic [hbus_pkg::FIFO_DW-1:0] rsp_rdata;
  logic                         rsp_ready;
  logic [hbus_pkg::HBUS_AW-1:0] hbus_adr;
  logic [hbus_pkg::HBUS_DW-1:0] bus_wdat;
  logic [hbus_pkg::HBUS_DW-1:0] bus_rdat;
  logic                         rrq;
  logic                         wrq;
  logic                         bus_ready;
  logic                         bus_valid;
  logic                         busy;
  logic                         wr_done;
  logic [hbus_pkg::HBUS_AW-1:0] wr_addr;
  logic [hbus_pkg::FIFO_DW-1:0] wr_word;
  int                           wr_beats;

  // Scoreboard
  logic [hbus_pkg::FIFO_DW-1:0] sb_mem [logic [hbus_pkg::HBUS_AW-1:0]];
  logic [hbus_pkg::FIFO_DW-1:0] exp_rsp [$];
  logic [63:0]                  exp_wr [$];
  logic [hbus_pkg::HBUS_AW-1:0] adr_prev;
  logic [hbus_pkg::FIFO_DW-1:0] rdata_prev;
  logic                         rrq_prev;
  int                           rd_out;
  int                           rd_fin;
  int                           errors;
  int                           tests;
  int                           rsp_mode;

  hbus_fifo dut (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .req_valid_i  (req_valid),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_rdata_o  (rsp_rdata),
    .rsp_ready_i  (rsp_ready),
    .hbus_adr_o   (hbus_adr),
    .hbus_dat_o   (bus_wdat),
    .hbus_rrq_o   (rrq),
    .hbus_wrq_o   (wrq),
    .hbus_dat_i   (bus_rdat),
    .hbus_ready_i (bus_ready),
    .hbus_valid_i (bus_valid),
    .hbus_busy_i  (busy)
  );

  hbus_mem_model u_mem (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .hbus_adr_i   (hbus_adr),
    .hbus_dat_i   (bus_wdat),
    .hbus_rrq_i   (rrq),
    .hbus_wrq_i   (wrq),
    .hbus_dat_o   (bus_rdat),
    .hbus_ready_o (bus_ready),
    .hbus_valid_o (bus_valid),
    .hbus_busy_o  (busy),
    .wr_done_o    (wr_done),
    .wr_addr_o    (wr_addr),
    .wr_word_o    (wr_word),
    .wr_beats_o   (wr_beats)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] default_word(input logic [31:0] addr);
    return {addr[15:0], ~addr[15:0]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Monitor and scoreboard sampled on the rising edge
  always @(posedge clk) begin
    adr_prev   <= hbus_adr;
    rdata_prev <= rsp_rdata;
    rrq_prev   <= rrq;
    if (hbus_rst) begin
      rd_out <= 0;
      rd_fin <= 0;
    end else begin
      if (req_valid && req_ready && req_write) begin
        sb_mem[req_addr] = req_wdata;
        exp_wr.push_back({req_addr, req_wdata});
      end else if (req_valid && req_ready) begin
        exp_rsp.push_back(sb_mem.exists(req_addr) ? sb_mem[req_addr] : default_word(req_addr));
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_rsp.size() == 0) begin
          errors++;
          $display("Fail at %0t: response arrived with no read pending", $time);
        end else begin
          check_eq("rsp_rdata_o", exp_rsp.pop_front(), rsp_rdata);
        end
      end
      if (wr_done && exp_wr.size() == 0) begin
        errors++;
        $display("Fail at %0t: bus write seen with no write pending", $time);
      end else if (wr_done) begin
        check_eq("write beat count", hbus_pkg::BEATS, wr_beats);
        check_eq("hbus_adr_o", exp_wr[0][63:32], wr_addr);
        check_eq("hbus_dat_o word", exp_wr[0][31:0], wr_word);
        void'(exp_wr.pop_front());
      end
      // Reads finished on the bus
      if (rrq_prev && !rrq) begin
        rd_fin <= rd_fin + 1;
      end
      rd_out <= rd_out + int'(req_valid && req_ready && !req_write) - int'(rsp_valid && rsp_ready);
    end
  end

  // Response back-pressure
  always @(posedge clk) begin
    #1;
    case (rsp_mode)
      RSP_HOLD: rsp_ready = 1'b0;
      RSP_ON:   rsp_ready = 1'b1;
      default:  rsp_ready = ($urandom_range(1, 0) == 1);
    endcase
  end

  a_req_excl: assert property (@(posedge clk) disable iff (hbus_rst) !(wrq && rrq))
    else begin
      errors++;
      $display("Fail at %0t: hbus_wrq_o and hbus_rrq_o high together", $time);
    end

  a_adr_hold: assert property (@(posedge clk) disable iff (hbus_rst)
    (wrq || rrq) && $past(wrq || rrq) |-> hbus_adr == adr_prev)
    else begin
      errors++;
      $display("Fail at %0t: hbus_adr_o expected %h got %h", $time,
               $sampled(adr_prev), $sampled(hbus_adr));
    end

  a_busy_start: assert property (@(posedge clk) disable iff (hbus_rst)
    $rose(wrq || rrq) |-> !$past(busy))
    else begin
      errors++;
      $display("Fail at %0t: request line rose while hbus_busy_i was high", $time);
    end

  a_credit_stop: assert property (@(posedge clk) disable iff (hbus_rst)
    rd_out >= hbus_pkg::FIFO_DEPTH && req_valid && !req_write |-> !req_ready)
    else begin
      errors++;
      $display("Fail at %0t: req_ready_o expected 0 got 1", $time);
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (hbus_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && rsp_rdata == rdata_prev)
    else begin
      errors++;
      $display("Fail at %0t: rsp_rdata_o expected %h got %h", $time,
               $sampled(rdata_prev), $sampled(rsp_rdata));
    end

  task automatic set_rsp_mode(input int mode);
    @(posedge clk);
    rsp_mode = mode;
    #1;
  endtask

  task automatic send_req(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    int t;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = data;
    t = 0;
    @(posedge clk);
    while (!req_ready && t < TMO) begin
      t++;
      @(posedge clk);
    end
    if (t >= TMO) begin
      errors++;
      $display("Timeout at %0t: request was never accepted", $time);
    end
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while ((exp_rsp.size() != 0 || exp_wr.size() != 0) && t < TMO * 20) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (t >= TMO * 20) begin
      errors++;
      $display("Timeout at %0t: pending reads or writes never completed", $time);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s finished with %0d errors", name, errors - err_before);
  endtask

  initial begin
    int base_err;
    int rd_base;
    int t;
    void'($urandom(32'hdcfe1bef));
    errors    = 0;
    tests     = 0;
    rsp_mode  = RSP_ON;
    rsp_ready = 1'b0;
    hbus_rst  = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    repeat (3) @(posedge clk);
    #1;
    hbus_rst = 1'b0;

    base_err = errors;
    check_eq("req_ready_o", 1, req_ready);
    check_eq("rsp_valid_o", 0, rsp_valid);
    check_eq("hbus_wrq_o", 0, wrq);
    check_eq("hbus_rrq_o", 0, rrq);
    report_test("reset_state", base_err);

    base_err = errors;
    send_req(1'b1, 32'h0000_0100, $urandom);
    send_req(1'b0, 32'h0000_0100, '0);
    send_req(1'b0, 32'h0000_2468, '0);
    wait_idle();
    report_test("single_write_read", base_err);

    base_err = errors;
    set_rsp_mode(RSP_RAND);
    for (int i = 0; i < 200; i++) begin
      send_req($urandom_range(1, 0), 32'h40 + 4 * $urandom_range(7, 0), $urandom);
    end
    wait_idle();
    report_test("random_stream", base_err);

    // Hold responses until the read credits run out
    base_err = errors;
    set_rsp_mode(RSP_HOLD);
    rd_base = rd_fin;
    for (int i = 0; i < hbus_pkg::FIFO_DEPTH; i++) begin
      send_req(1'b0, 32'h40 + 4 * i, '0);
    end
    req_valid = 1'b1;
    req_write = 1'b0;
    req_addr  = 32'h0000_0100;
    t = 0;
    while (rd_fin - rd_base < hbus_pkg::FIFO_DEPTH && t < TMO) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (t >= TMO) begin
      errors++;
      $display("Timeout at %0t: held reads never completed on the bus", $time);
    end
    check_eq("req_ready_o", 0, req_ready);
    check_eq("rsp_valid_o", 1, rsp_valid);
    req_valid = 1'b0;
    set_rsp_mode(RSP_ON);
    send_req(1'b0, 32'h0000_0100, '0);
    wait_idle();
    report_test("read_credits", base_err);

    base_err = errors;
    set_rsp_mode(RSP_RAND);
    for (int i = 0; i < 40; i++) begin
      send_req(1'b1, 32'h80 + 4 * $urandom_range(7, 0), $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      send_req(1'b0, 32'h80 + 4 * i, '0);
    end
    wait_idle();
    report_test("write_stalls", base_err);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: all.f
rtl/hbus_pkg.sv
rtl/hbus_sync_fifo.sv
rtl/hbus_req_port.sv
rtl/hbus_xfer_fsm.sv
rtl/hbus_fifo.sv
testbench/hbus_mem_model.sv
testbench/tb_hbus_fifo.sv

// File: Bender.yml
package:
  name: hbus_fifo

sources:
  - files:
      - rtl/hbus_pkg.sv
      - rtl/hbus_sync_fifo.sv
      - rtl/hbus_req_port.sv
      - rtl/hbus_xfer_fsm.sv
      - rtl/hbus_fifo.sv
  - target: test
    files:
      - testbench/hbus_mem_model.sv
      - testbench/tb_hbus_fifo.sv
